/* verilog/risk_cfg.svh */
// ##########################################################################
// widths and table depth shared by the risk gate RTL and its testbench
// amounts, limits and totals are unsigned, one common width
// client id must index the whole table, so 2**client bits >= clients
// ##########################################################################

`ifndef RISK_CFG_SVH
`define RISK_CFG_SVH

// client id width
`define RISK_CLIENT_BITS 5

// width of order amounts, cancellations, the limit and the accumulator
`define RISK_AMOUNT_BITS 16

// entries in the per-client cancelled table
`define RISK_NUM_CLIENTS 32

`endif

/* verilog/risk_pkg.sv */
// ##########################################################################
// packed structs passed between decode, execute and result stages
// field widths come from the cfg header
// ##########################################################################

`include "risk_cfg.svh"

package risk_pkg;

  // registered cpu command
  // valid is the order strobe, new_max the limit-load strobe
  // amount carries the order amount or the new limit
  typedef struct packed {
    logic                          valid;
    logic                          new_max;
    logic [`RISK_CLIENT_BITS-1:0]  client_id;
    logic [`RISK_AMOUNT_BITS-1:0]  amount;
  } order_cmd_t;

  // registered cancellation report from the exchange
  typedef struct packed {
    logic                          valid;
    logic [`RISK_CLIENT_BITS-1:0]  client_id;
    logic [`RISK_AMOUNT_BITS-1:0]  amount;
  } cancel_evt_t;

  // outcome of one order in execute
  // cancelled is the client total the rule actually used,
  // same-cycle cancellation included
  // accum is the accumulator after this order
  typedef struct packed {
    logic                          done;
    logic                          accept;
    logic [`RISK_CLIENT_BITS-1:0]  client_id;
    logic [`RISK_AMOUNT_BITS-1:0]  amount;
    logic [`RISK_AMOUNT_BITS-1:0]  cancelled;
    logic [`RISK_AMOUNT_BITS-1:0]  accum;
  } exec_result_t;

endpackage

/* verilog/event_decode.sv */
// ##########################################################################
// decode stage: port strobes are captured on the sampling edge,
// commands leave one cycle later with priority already resolved
// new_max beats cpu_go in the same cycle, the order is dropped
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module event_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`RISK_CLIENT_BITS-1:0]  cpu_client_id,
  input  logic [`RISK_AMOUNT_BITS-1:0]  cpu_amount,
  input  logic                          cpu_go,
  input  logic                          cpu_new_max,
  input  logic [`RISK_CLIENT_BITS-1:0]  exchange_client_id,
  input  logic [`RISK_AMOUNT_BITS-1:0]  exchange_amount,
  input  logic                          exchange_go,
  output risk_pkg::order_cmd_t          order_cmd,
  output risk_pkg::cancel_evt_t         cancel_evt
);

  // capture flops at the ports
  logic                          cap_go;
  logic                          cap_max;
  logic                          cap_exch;
  logic [`RISK_CLIENT_BITS-1:0]  cap_cpu_id;
  logic [`RISK_AMOUNT_BITS-1:0]  cap_cpu_amt;
  logic [`RISK_CLIENT_BITS-1:0]  cap_exch_id;
  logic [`RISK_AMOUNT_BITS-1:0]  cap_exch_amt;

  // decoded command flops
  logic                          ord_valid;
  logic                          ord_max;
  logic                          can_valid;
  logic [`RISK_CLIENT_BITS-1:0]  ord_id;
  logic [`RISK_AMOUNT_BITS-1:0]  ord_amt;
  logic [`RISK_CLIENT_BITS-1:0]  can_id;
  logic [`RISK_AMOUNT_BITS-1:0]  can_amt;

  // strobes, cleared on reset so execute never sees stale payloads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_go    <= 1'b0;
      cap_max   <= 1'b0;
      cap_exch  <= 1'b0;
      ord_valid <= 1'b0;
      ord_max   <= 1'b0;
      can_valid <= 1'b0;
    end else begin
      cap_go    <= cpu_go;
      cap_max   <= cpu_new_max;
      cap_exch  <= exchange_go;
      // limit load wins, order is dropped
      ord_valid <= cap_go & ~cap_max;
      ord_max   <= cap_max;
      can_valid <= cap_exch;
    end
  end

  // payload just follows the strobes
  always_ff @(posedge clk) begin
    cap_cpu_id   <= cpu_client_id;
    cap_cpu_amt  <= cpu_amount;
    cap_exch_id  <= exchange_client_id;
    cap_exch_amt <= exchange_amount;
    ord_id       <= cap_cpu_id;
    ord_amt      <= cap_cpu_amt;
    can_id       <= cap_exch_id;
    can_amt      <= cap_exch_amt;
  end

  assign order_cmd = '{valid: ord_valid, new_max: ord_max, client_id: ord_id, amount: ord_amt};
  assign cancel_evt = '{valid: can_valid, client_id: can_id, amount: can_amt};

endmodule

/* verilog/exposure_exec.sv */
// ##########################################################################
// execute stage: table read, rule and all state writes in one cycle
// safe when limit > accumulated + amount - cancelled(client)
// table entries and the accumulator saturate at all ones
// a cancellation for the order's client in the same cycle counts first
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module exposure_exec (
  input  logic                          clk,
  input  logic                          rst_n,
  input  risk_pkg::order_cmd_t          order_cmd,
  input  risk_pkg::cancel_evt_t         cancel_evt,
  output risk_pkg::exec_result_t        exec_res,
  output logic [`RISK_AMOUNT_BITS-1:0]  accumulated_orders,
  output logic [`RISK_AMOUNT_BITS-1:0]  max_to_trade
);

  localparam int AW = `RISK_AMOUNT_BITS;

  // per-client cancelled totals
  logic [AW-1:0]         cancel_tbl [`RISK_NUM_CLIENTS];
  logic [AW-1:0]         limit_q;
  logic [AW-1:0]         accum_q;

  // cancellation path
  logic [AW:0]           cancel_wide;
  logic [AW-1:0]         cancel_sum;
  logic                  same_client;
  logic [AW-1:0]         eff_cancel;

  // rule and accumulator path
  logic signed [AW:0]    headroom;
  logic signed [AW:0]    net_exposure;
  logic                  order_safe;
  logic                  accept;
  logic [AW:0]           accum_wide;
  logic [AW-1:0]         accum_sat;

  // result flops
  logic                  res_done;
  logic                  res_accept;
  logic [`RISK_CLIENT_BITS-1:0] res_id;
  logic [AW-1:0]         res_amt;
  logic [AW-1:0]         res_cancel;
  logic [AW-1:0]         res_accum;

  always_comb begin
    // new entry for the reporting client, saturating
    cancel_wide = {1'b0, cancel_tbl[cancel_evt.client_id]} + {1'b0, cancel_evt.amount};
    cancel_sum  = cancel_wide[AW] ? {AW{1'b1}} : cancel_wide[AW-1:0];

    // forward a same-cycle cancellation into the rule
    same_client = cancel_evt.valid && (cancel_evt.client_id == order_cmd.client_id);
    eff_cancel  = same_client ? cancel_sum : cancel_tbl[order_cmd.client_id];

    // rule rearranged as limit - amount > accum - cancelled
    // both sides fit in one extra signed bit, so nothing wraps
    headroom     = $signed({1'b0, limit_q}) - $signed({1'b0, order_cmd.amount});
    net_exposure = $signed({1'b0, accum_q}) - $signed({1'b0, eff_cancel});
    order_safe   = headroom > net_exposure;
    accept       = order_cmd.valid & order_safe;

    // accumulator after an accepted order
    accum_wide = {1'b0, accum_q} + {1'b0, order_cmd.amount};
    accum_sat  = accum_wide[AW] ? {AW{1'b1}} : accum_wide[AW-1:0];
  end

  // cancelled table, all zero after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RISK_NUM_CLIENTS; i++) begin
        cancel_tbl[i] <= '0;
      end
    end else if (cancel_evt.valid) begin
      cancel_tbl[cancel_evt.client_id] <= cancel_sum;
    end
  end

  // limit and accumulator
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      limit_q <= '0;
      accum_q <= '0;
    end else begin
      if (order_cmd.new_max) begin
        limit_q <= order_cmd.amount;
      end
      // rejected orders leave the total alone
      if (accept) begin
        accum_q <= accum_sat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_done <= 1'b0;
    end else begin
      res_done <= order_cmd.valid;
    end
  end

  // outcome payload, qualified by res_done downstream
  always_ff @(posedge clk) begin
    res_accept <= accept;
    res_id     <= order_cmd.client_id;
    res_amt    <= order_cmd.amount;
    res_cancel <= eff_cancel;
    res_accum  <= accept ? accum_sat : accum_q;
  end

  assign exec_res = '{
    done:      res_done,
    accept:    res_accept,
    client_id: res_id,
    amount:    res_amt,
    cancelled: res_cancel,
    accum:     res_accum
  };

  // live state straight to the top
  assign accumulated_orders = accum_q;
  assign max_to_trade       = limit_q;

endmodule

/* verilog/trade_verdict.sv */
// ##########################################################################
// result stage: one register level between execute and the outputs
// client id and cancelled total hold the last completed order
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module trade_verdict (
  input  logic                          clk,
  input  logic                          rst_n,
  input  risk_pkg::exec_result_t        exec_res,
  output logic                          trade_done,
  output logic                          trade_accept,
  output logic [`RISK_CLIENT_BITS-1:0]  trade_client_id,
  output logic [`RISK_AMOUNT_BITS-1:0]  cancelled_orders
);

  // verdict strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trade_done   <= 1'b0;
      trade_accept <= 1'b0;
    end else begin
      trade_done   <= exec_res.done;
      // accept only ever rides with done
      trade_accept <= exec_res.done & exec_res.accept;
    end
  end

  // display registers, load on a completed order only
  always_ff @(posedge clk) begin
    if (exec_res.done) begin
      trade_client_id  <= exec_res.client_id;
      cancelled_orders <= exec_res.cancelled;
    end
  end

endmodule

/* verilog/risk_gate_top.sv */
// ##########################################################################
// pre-trade risk gate, decode -> execute -> result
// order sampled at edge N shows trade_done after edge N+3
// limit loads and cancellations apply at edge N+2, no back-pressure
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module risk_gate_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`RISK_CLIENT_BITS-1:0]  cpu_client_id,
  input  logic [`RISK_AMOUNT_BITS-1:0]  cpu_amount,
  input  logic                          cpu_go,
  input  logic                          cpu_new_max,
  input  logic [`RISK_CLIENT_BITS-1:0]  exchange_client_id,
  input  logic [`RISK_AMOUNT_BITS-1:0]  exchange_amount,
  input  logic                          exchange_go,
  output logic                          trade_done,
  output logic                          trade_accept,
  output logic [`RISK_CLIENT_BITS-1:0]  trade_client_id,
  output logic [`RISK_AMOUNT_BITS-1:0]  cancelled_orders,
  output logic [`RISK_AMOUNT_BITS-1:0]  accumulated_orders,
  output logic [`RISK_AMOUNT_BITS-1:0]  max_to_trade
);

  // stage buses, widths follow the packed command and result layouts
  localparam int ORDER_W  = 2 + `RISK_CLIENT_BITS + `RISK_AMOUNT_BITS;
  localparam int CANCEL_W = 1 + `RISK_CLIENT_BITS + `RISK_AMOUNT_BITS;
  localparam int RESULT_W = 2 + `RISK_CLIENT_BITS + 3 * `RISK_AMOUNT_BITS;

  logic [ORDER_W-1:0]   order_cmd;
  logic [CANCEL_W-1:0]  cancel_evt;
  logic [RESULT_W-1:0]  exec_res;

  event_decode i_decode (
    .clk                (clk),
    .rst_n              (rst_n),
    .cpu_client_id      (cpu_client_id),
    .cpu_amount         (cpu_amount),
    .cpu_go             (cpu_go),
    .cpu_new_max        (cpu_new_max),
    .exchange_client_id (exchange_client_id),
    .exchange_amount    (exchange_amount),
    .exchange_go        (exchange_go),
    .order_cmd          (order_cmd),
    .cancel_evt         (cancel_evt)
  );

  exposure_exec i_exec (
    .clk                (clk),
    .rst_n              (rst_n),
    .order_cmd          (order_cmd),
    .cancel_evt         (cancel_evt),
    .exec_res           (exec_res),
    .accumulated_orders (accumulated_orders),
    .max_to_trade       (max_to_trade)
  );

  trade_verdict i_verdict (
    .clk                (clk),
    .rst_n              (rst_n),
    .exec_res           (exec_res),
    .trade_done         (trade_done),
    .trade_accept       (trade_accept),
    .trade_client_id    (trade_client_id),
    .cancelled_orders   (cancelled_orders)
  );

endmodule

/* verif/risk_gate_asserts.sv */
// ##########################################################################
// concurrent checks on the risk gate outputs, bound into the top level
// sampled on the rising clock, idle while reset is held
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module risk_gate_asserts (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          trade_done,
  input  logic                          trade_accept,
  input  logic [`RISK_AMOUNT_BITS-1:0]  accumulated_orders
);

  // accept is only meaningful together with done
  accept_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    trade_accept |-> trade_done)
    else $error("trade_accept was high while trade_done was low");

  // pipeline is three stages deep, nothing can complete earlier
  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !trade_done ##1 !trade_done ##1 !trade_done)
    else $error("trade_done rose within three cycles of reset release");

  // accumulator only adds, saturation holds it at all ones
  accum_never_falls: assert property (@(posedge clk) disable iff (!rst_n)
    accumulated_orders >= $past(accumulated_orders))
    else $error("accumulated_orders went down");

  // accumulator moves at the execute edge, the accepted verdict follows
  // one cycle later on the result stage
  accum_step_is_accept: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(accumulated_orders) |=> trade_accept)
    else $error("accumulated_orders changed without an accepted trade");

endmodule

/* verif/risk_gate_tb.sv */
// ##########################################################################
// risk gate testbench with directed cases and a seeded random burst
// inputs change and outputs are checked on the falling edge
// model takes one input cycle at a time with cancellation first
// and then the limit load or the order
// ##########################################################################

`timescale 1ns/1ps
`include "risk_cfg.svh"

module risk_gate_tb;

  typedef logic [`RISK_CLIENT_BITS-1:0] client_t;
  typedef logic [`RISK_AMOUNT_BITS-1:0] amount_t;

  // expected verdict and the falling edge it is due on
  typedef struct packed {
    logic [31:0]             due;
    risk_pkg::exec_result_t  res;
  } pending_t;

  // live totals expected on the outputs
  typedef struct packed {
    amount_t accum;
    amount_t limit;
  } totals_t;

  localparam int AMOUNT_MAX   = (1 << `RISK_AMOUNT_BITS) - 1;
  localparam int DIRECTED_OPS = 40;
  localparam int RANDOM_OPS   = 600;
  localparam int DRAIN_OPS    = 8;
  localparam int NUM_OPS      = DIRECTED_OPS + RANDOM_OPS + DRAIN_OPS;
  localparam int WATCHDOG_NS  = (NUM_OPS + 20) * 20;
  // order driven on falling edge k completes on falling edge k+4
  localparam int DONE_LAG     = 4;
  // limit and accumulator show up three falling edges after the drive
  localparam int TOTALS_LAG   = 3;

  logic     clk;
  logic     rst_n;
  client_t  cpu_client_id;
  amount_t  cpu_amount;
  logic     cpu_go;
  logic     cpu_new_max;
  client_t  exchange_client_id;
  amount_t  exchange_amount;
  logic     exchange_go;
  logic     trade_done;
  logic     trade_accept;
  client_t  trade_client_id;
  amount_t  cancelled_orders;
  amount_t  accumulated_orders;
  amount_t  max_to_trade;

  // reference state
  amount_t     cancel_model [`RISK_NUM_CLIENTS];
  amount_t     accum_model;
  amount_t     limit_model;
  pending_t    exp_q[$];
  totals_t     tot_q[$];
  int unsigned stim_cyc;

  risk_gate_top i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .cpu_client_id      (cpu_client_id),
    .cpu_amount         (cpu_amount),
    .cpu_go             (cpu_go),
    .cpu_new_max        (cpu_new_max),
    .exchange_client_id (exchange_client_id),
    .exchange_amount    (exchange_amount),
    .exchange_go        (exchange_go),
    .trade_done         (trade_done),
    .trade_accept       (trade_accept),
    .trade_client_id    (trade_client_id),
    .cancelled_orders   (cancelled_orders),
    .accumulated_orders (accumulated_orders),
    .max_to_trade       (max_to_trade)
  );

  bind risk_gate_top risk_gate_asserts i_asserts (
    .clk                (clk),
    .rst_n              (rst_n),
    .trade_done         (trade_done),
    .trade_accept       (trade_accept),
    .accumulated_orders (accumulated_orders)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic amount_t sat_add(amount_t a, amount_t b);
    int sum;
    sum = int'(a) + int'(b);
    return (sum > AMOUNT_MAX) ? amount_t'(AMOUNT_MAX) : amount_t'(sum);
  endfunction

  // safe when limit > accumulated + amount - cancelled in signed math
  function automatic risk_pkg::exec_result_t ref_order(client_t cid, amount_t amt,
                                                       amount_t cancelled, amount_t accum,
                                                       amount_t limit);
    risk_pkg::exec_result_t r;
    int exposure;
    exposure    = int'(accum) + int'(amt) - int'(cancelled);
    r.done      = 1'b1;
    r.accept    = int'(limit) > exposure;
    r.client_id = cid;
    r.amount    = amt;
    r.cancelled = cancelled;
    r.accum     = r.accept ? sat_add(accum, amt) : accum;
    return r;
  endfunction

  // small, medium, near full scale or anything
  function automatic amount_t pick_amount();
    int unsigned kind;
    kind = $urandom % 4;
    case (kind)
      0: return amount_t'($urandom % 256);
      1: return amount_t'($urandom % 4096);
      2: return amount_t'(AMOUNT_MAX - ($urandom % 1024));
      default: return amount_t'($urandom);
    endcase
  endfunction

  // mostly a few clients so entries collide and saturate
  function automatic client_t pick_client();
    if (($urandom % 4) == 0) begin
      return client_t'($urandom);
    end
    return client_t'($urandom % 6);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_client(input string name, input client_t exp, input client_t got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_amount(input string name, input amount_t exp, input amount_t got);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s expected 0x%h got 0x%h", name, exp, got));
    end
  endtask

  task automatic check_verdict(input risk_pkg::exec_result_t exp);
    check_flag("trade_accept", exp.accept, trade_accept);
    check_client("trade_client_id", exp.client_id, trade_client_id);
    check_amount("cancelled_orders", exp.cancelled, cancelled_orders);
  endtask

  // one input cycle and the model update it causes
  task automatic drive_cycle(input logic go, input logic new_max, input client_t cid,
                             input amount_t amt, input logic xgo, input client_t xcid,
                             input amount_t xamt);
    pending_t p;
    totals_t  t;
    @(negedge clk);
    cpu_go             = go;
    cpu_new_max        = new_max;
    cpu_client_id      = cid;
    cpu_amount         = amt;
    exchange_go        = xgo;
    exchange_client_id = xcid;
    exchange_amount    = xamt;
    // cancellation counts before a same-cycle order
    if (xgo) begin
      cancel_model[xcid] = sat_add(cancel_model[xcid], xamt);
    end
    // limit load drops a same-cycle order
    if (new_max) begin
      limit_model = amt;
    end else if (go) begin
      p.res       = ref_order(cid, amt, cancel_model[cid], accum_model, limit_model);
      p.due       = stim_cyc + DONE_LAG;
      accum_model = p.res.accum;
      exp_q.push_back(p);
    end
    t.accum = accum_model;
    t.limit = limit_model;
    tot_q.push_back(t);
    stim_cyc++;
  endtask

  task automatic send_order(input client_t cid, input amount_t amt);
    drive_cycle(1'b1, 1'b0, cid, amt, 1'b0, '0, '0);
  endtask

  task automatic load_limit(input amount_t amt);
    drive_cycle(1'b0, 1'b1, '0, amt, 1'b0, '0, '0);
  endtask

  task automatic send_cancel(input client_t cid, input amount_t amt);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, cid, amt);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  // compares verdicts at trade_done and the totals on every falling edge
  initial begin : compare_outputs
    pending_t    p;
    totals_t     t;
    int unsigned cyc;
    cyc = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (tot_q.size() == 0) begin
        fail_run("checker ran out of expected totals");
      end
      t = tot_q.pop_front();
      check_amount("accumulated_orders", t.accum, accumulated_orders);
      check_amount("max_to_trade", t.limit, max_to_trade);
      if (trade_done === 1'b1) begin
        if (exp_q.size() == 0) begin
          fail_run("trade_done came with no order in flight");
        end
        p = exp_q.pop_front();
        if (p.due != cyc) begin
          fail_run("trade_done did not come three cycles after its order");
        end
        check_verdict(p.res);
      end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        fail_run("trade_done missing three cycles after an order");
      end
      cyc++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin : run_tests
    totals_t zero;
    void'($urandom(57));
    rst_n              = 1'b0;
    cpu_client_id      = '0;
    cpu_amount         = '0;
    cpu_go             = 1'b0;
    cpu_new_max        = 1'b0;
    exchange_client_id = '0;
    exchange_amount    = '0;
    exchange_go        = 1'b0;
    for (int i = 0; i < `RISK_NUM_CLIENTS; i++) begin
      cancel_model[i] = '0;
    end
    accum_model = '0;
    limit_model = '0;
    stim_cyc    = 0;
    zero        = '0;
    // outputs hold reset values until the first drive lands
    repeat (TOTALS_LAG) tot_q.push_back(zero);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // no limit yet so all are rejected
    send_order(5'd3, 16'd10);
    send_order(5'd4, 16'd1);
    send_order(5'd5, 16'd0);
    idle_cycles(4);

    // fill up to the limit where the last ones fail the rule
    load_limit(16'd1000);
    repeat (4) send_order(5'd1, 16'd300);
    send_order(5'd1, 16'd99);
    send_order(5'd2, 16'd1);
    idle_cycles(4);

    // headroom for client 2 only and then a saturated entry on client 6
    send_cancel(5'd2, 16'd500);
    send_order(5'd2, 16'd400);
    send_order(5'd1, 16'd1);
    send_cancel(5'd6, 16'hfff0);
    send_cancel(5'd6, 16'h0100);
    send_order(5'd6, 16'h0010);
    idle_cycles(4);

    // same-cycle cancel and order, other client, then limit beats order
    drive_cycle(1'b1, 1'b0, 5'd7, 16'd200, 1'b1, 5'd7, 16'd700);
    drive_cycle(1'b1, 1'b0, 5'd8, 16'd10, 1'b1, 5'd9, 16'd5000);
    drive_cycle(1'b1, 1'b1, 5'd3, 16'd2000, 1'b0, '0, '0);
    send_order(5'd3, 16'd1);
    idle_cycles(4);

    // back-to-back random mix
    for (int i = 0; i < RANDOM_OPS; i++) begin
      drive_cycle(($urandom % 4) != 0, ($urandom % 16) == 0, pick_client(), pick_amount(),
                  ($urandom % 2) == 0, pick_client(), pick_amount());
    end
    idle_cycles(DRAIN_OPS);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+verilog
verilog/risk_pkg.sv
verilog/event_decode.sv
verilog/exposure_exec.sv
verilog/trade_verdict.sv
verilog/risk_gate_top.sv
verif/risk_gate_asserts.sv
verif/risk_gate_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := risk_gate_tb
RTL_TOP    := risk_gate_top
FILE_LIST  := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTS FAILED
SIM_FLAGS  := --binary --assert --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
